//--- source/debug_pkg.sv
////////////////////////////////////////
// Debug card shared definitions
// Bus widths, command addresses, decoded
// commands, print formats and run states
////////////////////////////////////////

package debug_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////
   localparam int WORD_W    = 16;          // Backplane data bus
   localparam int LONG_W    = 32;          // Print payload
   localparam int IO_ADDR_W = 8;           // Offset in the 1xx page
   localparam int AB_W      = 24;          // Full backplane address bus
   localparam int FPD_W     = 8;           // Front panel data

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [LONG_W-1:0]    long_t;
   typedef logic [IO_ADDR_W-1:0] io_addr_t;

   ////////////////////////////////////////
   // Command addresses in the low byte of ab
   ////////////////////////////////////////
   localparam io_addr_t ADDR_SOR       = 8'h00;
   localparam io_addr_t ADDR_ENEF      = 8'h08;
   localparam io_addr_t ADDR_DISEF     = 8'h09;
   localparam io_addr_t ADDR_SENTINEL  = 8'h0F;
   localparam io_addr_t ADDR_PRINTA    = 8'h10;
   localparam io_addr_t ADDR_PRINTC    = 8'h11;
   localparam io_addr_t ADDR_PRINTD    = 8'h12;
   localparam io_addr_t ADDR_PRINTU    = 8'h13;
   localparam io_addr_t ADDR_PRINTH    = 8'h14;
   localparam io_addr_t ADDR_PRINTB    = 8'h15;
   localparam io_addr_t ADDR_PRINTSP   = 8'h16;
   localparam io_addr_t ADDR_PRINTNL   = 8'h17;
   localparam io_addr_t ADDR_DEBUGON   = 8'h18;
   localparam io_addr_t ADDR_DEBUGOFF  = 8'h19;
   localparam io_addr_t ADDR_DUMP      = 8'h1A;
   localparam io_addr_t ADDR_PRINTHI   = 8'h1B;
   localparam io_addr_t ADDR_PRINTLO   = 8'h1C;
   localparam io_addr_t ADDR_HALT      = 8'h1D;
   localparam io_addr_t ADDR_SUCCESS   = 8'h1E;
   localparam io_addr_t ADDR_FAIL      = 8'h1F;

   // Fixed characters for PRINTSP and PRINTNL
   localparam word_t CHAR_SPACE   = 16'd32;
   localparam word_t CHAR_NEWLINE = 16'd10;

   ////////////////////////////////////////
   // Enums
   ////////////////////////////////////////
   typedef enum logic [3:0] {
      CMD_NONE, CMD_SOR, CMD_PRINT, CMD_PRINTHI, CMD_PRINTLO,
      CMD_UNSUP, CMD_SENTINEL, CMD_HALT, CMD_SUCCESS, CMD_FAIL, CMD_UNKNOWN
   } cmd_t;

   typedef enum logic [2:0] {
      FMT_ADDR, FMT_CHAR, FMT_SDEC, FMT_UDEC, FMT_HEX, FMT_BIN, FMT_LONG
   } print_fmt_t;

   typedef enum logic [1:0] {ST_RUN, ST_HALTED, ST_TRAPPED} run_state_t;

   // Why the processor was stopped
   typedef enum logic [1:0] {
      RSN_NONE, RSN_HALT, RSN_SENTINEL, RSN_UNKNOWN
   } halt_reason_t;

endpackage

//--- source/debug_decode.sv
////////////////////////////////////////
// Debug card decode stage
// Registers each write in the 1xx page and
// maps its address to a command code
////////////////////////////////////////

`timescale 1ns/10ps

module debug_decode (
   input  logic                    nw,         // Bus write strobe
   input  logic                    rst,
   input  logic                    niodev1xx,  // Low selects I/O 100-1FF
   input  debug_pkg::io_addr_t     ab,
   input  debug_pkg::word_t        db,
   output debug_pkg::cmd_t         cmd,
   output debug_pkg::print_fmt_t   fmt,
   output debug_pkg::word_t        cmd_data,
   output debug_pkg::io_addr_t     cmd_addr
);

   debug_pkg::cmd_t       next_cmd;
   debug_pkg::print_fmt_t next_fmt;
   debug_pkg::word_t      next_data;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////
   always_comb begin
      next_cmd  = debug_pkg::CMD_NONE;
      next_fmt  = debug_pkg::FMT_HEX;
      next_data = db;                      // Most commands pass db through
      if (!niodev1xx) begin
         case (ab)
            debug_pkg::ADDR_SOR:      next_cmd = debug_pkg::CMD_SOR;
            debug_pkg::ADDR_SENTINEL: next_cmd = debug_pkg::CMD_SENTINEL;
            debug_pkg::ADDR_PRINTA: begin
               next_cmd = debug_pkg::CMD_PRINT;
               next_fmt = debug_pkg::FMT_ADDR;
            end
            debug_pkg::ADDR_PRINTC: begin
               next_cmd = debug_pkg::CMD_PRINT;
               next_fmt = debug_pkg::FMT_CHAR;
            end
            debug_pkg::ADDR_PRINTD: begin
               next_cmd = debug_pkg::CMD_PRINT;
               next_fmt = debug_pkg::FMT_SDEC;
            end
            debug_pkg::ADDR_PRINTU: begin
               next_cmd = debug_pkg::CMD_PRINT;
               next_fmt = debug_pkg::FMT_UDEC;
            end
            debug_pkg::ADDR_PRINTH: begin
               next_cmd = debug_pkg::CMD_PRINT;
               next_fmt = debug_pkg::FMT_HEX;
            end
            debug_pkg::ADDR_PRINTB: begin
               next_cmd = debug_pkg::CMD_PRINT;
               next_fmt = debug_pkg::FMT_BIN;
            end
            debug_pkg::ADDR_PRINTSP: begin
               next_cmd  = debug_pkg::CMD_PRINT;
               next_fmt  = debug_pkg::FMT_CHAR;
               next_data = debug_pkg::CHAR_SPACE;     // db ignored
            end
            debug_pkg::ADDR_PRINTNL: begin
               next_cmd  = debug_pkg::CMD_PRINT;
               next_fmt  = debug_pkg::FMT_CHAR;
               next_data = debug_pkg::CHAR_NEWLINE;   // db ignored
            end
            debug_pkg::ADDR_ENEF,
            debug_pkg::ADDR_DISEF,
            debug_pkg::ADDR_DEBUGON,
            debug_pkg::ADDR_DEBUGOFF,
            debug_pkg::ADDR_DUMP:     next_cmd = debug_pkg::CMD_UNSUP;
            debug_pkg::ADDR_PRINTHI:  next_cmd = debug_pkg::CMD_PRINTHI;
            debug_pkg::ADDR_PRINTLO: begin
               next_cmd = debug_pkg::CMD_PRINTLO;
               next_fmt = debug_pkg::FMT_LONG;
            end
            debug_pkg::ADDR_HALT:     next_cmd = debug_pkg::CMD_HALT;
            debug_pkg::ADDR_SUCCESS:  next_cmd = debug_pkg::CMD_SUCCESS;
            debug_pkg::ADDR_FAIL:     next_cmd = debug_pkg::CMD_FAIL;
            default:                  next_cmd = debug_pkg::CMD_UNKNOWN;
         endcase
      end
   end

   // Command register holds each write for one cycle
   always_ff @(posedge nw) begin
      if (rst) begin
         cmd <= debug_pkg::CMD_NONE;
      end else begin
         cmd <= next_cmd;                  // CMD_NONE on idle edges
      end
   end

   // Payload travels alongside the command
   always_ff @(posedge nw) begin
      fmt      <= next_fmt;
      cmd_data <= next_data;
      cmd_addr <= ab;
   end

endmodule

//--- source/debug_regs.sv
////////////////////////////////////////
// Debug card register block
// Output register, high-word latch, and
// the print and unsupported records
////////////////////////////////////////

`timescale 1ns/10ps

module debug_regs (
   input  logic                            nw,
   input  logic                            rst,
   input  debug_pkg::cmd_t                 cmd,
   input  debug_pkg::print_fmt_t           fmt,
   input  debug_pkg::word_t                cmd_data,
   input  debug_pkg::io_addr_t             cmd_addr,
   output debug_pkg::word_t                out_reg,
   output logic [debug_pkg::FPD_W-1:0]     fpd,
   output logic                            print_valid,
   output debug_pkg::print_fmt_t           print_fmt,
   output debug_pkg::long_t                print_data,
   output logic                            unsup_valid,
   output debug_pkg::io_addr_t             unsup_addr
);

   debug_pkg::word_t hi_word;              // PRINTHI latch for 32-bit prints

   ////////////////////////////////////////
   // Output register and high-word latch
   ////////////////////////////////////////
   always_ff @(posedge nw) begin
      if (rst) begin
         out_reg <= '0;
         hi_word <= '0;
      end else begin
         if (cmd == debug_pkg::CMD_SOR) begin
            out_reg <= cmd_data;
         end
         if (cmd == debug_pkg::CMD_PRINTHI) begin
            hi_word <= cmd_data;           // Held until the next PRINTHI
         end
      end
   end

   // Front panel shows the low byte
   assign fpd = out_reg[debug_pkg::FPD_W-1:0];

   ////////////////////////////////////////
   // Print records
   ////////////////////////////////////////
   always_ff @(posedge nw) begin
      if (rst) begin
         print_valid <= 1'b0;
         print_fmt   <= debug_pkg::FMT_ADDR;
         print_data  <= '0;
      end else begin
         print_valid <= 1'b0;              // Single-cycle pulse
         case (cmd)
            debug_pkg::CMD_PRINT: begin
               print_valid <= 1'b1;
               print_fmt   <= fmt;
               print_data  <= {{debug_pkg::WORD_W{1'b0}}, cmd_data};
            end
            debug_pkg::CMD_PRINTLO: begin
               print_valid <= 1'b1;
               print_fmt   <= debug_pkg::FMT_LONG;
               print_data  <= {hi_word, cmd_data};  // Latch forms the top half
            end
            default: begin
               // Fields hold for the logger
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Unsupported command records
   ////////////////////////////////////////
   always_ff @(posedge nw) begin
      if (rst) begin
         unsup_valid <= 1'b0;
         unsup_addr  <= '0;
      end else if (cmd == debug_pkg::CMD_UNSUP) begin
         unsup_valid <= 1'b1;
         unsup_addr  <= cmd_addr;          // Which command was not handled
      end else begin
         unsup_valid <= 1'b0;
      end
   end

   // ENEF, DISEF, DEBUGON, DEBUGOFF and DUMP are only reported
   // The processor keeps running after them

endmodule

//--- source/run_control.sv
////////////////////////////////////////
// Debug card run control
// Halt and trap FSM driving nhalt, plus
// sticky success and fail verdicts
////////////////////////////////////////

`timescale 1ns/10ps

module run_control (
   input  logic                       nw,
   input  logic                       rst,
   input  debug_pkg::cmd_t            cmd,
   input  debug_pkg::io_addr_t        cmd_addr,
   output logic                       nhalt,        // Low once stopped
   output debug_pkg::halt_reason_t    halt_reason,
   output debug_pkg::io_addr_t        bad_addr,
   output logic                       success,
   output logic                       fail
);

   debug_pkg::run_state_t   state;
   debug_pkg::run_state_t   next_state;
   debug_pkg::halt_reason_t next_reason;

   ////////////////////////////////////////
   // Next state
   ////////////////////////////////////////
   always_comb begin
      next_state  = state;
      next_reason = halt_reason;
      // Only the first stop counts and both stopped states are final
      if (state == debug_pkg::ST_RUN) begin
         case (cmd)
            debug_pkg::CMD_HALT: begin
               next_state  = debug_pkg::ST_HALTED;
               next_reason = debug_pkg::RSN_HALT;
            end
            debug_pkg::CMD_SENTINEL: begin
               next_state  = debug_pkg::ST_TRAPPED;
               next_reason = debug_pkg::RSN_SENTINEL;
            end
            debug_pkg::CMD_UNKNOWN: begin
               next_state  = debug_pkg::ST_TRAPPED;
               next_reason = debug_pkg::RSN_UNKNOWN;
            end
            default: begin
               next_state = debug_pkg::ST_RUN;
            end
         endcase
      end
   end

   // State, reason and trap address
   always_ff @(posedge nw) begin
      if (rst) begin
         state       <= debug_pkg::ST_RUN;
         halt_reason <= debug_pkg::RSN_NONE;
         bad_addr    <= '0;
      end else begin
         state       <= next_state;
         halt_reason <= next_reason;
         if (state == debug_pkg::ST_RUN && cmd == debug_pkg::CMD_UNKNOWN) begin
            bad_addr <= cmd_addr;          // Offending address
         end
      end
   end

   assign nhalt = (state == debug_pkg::ST_RUN);   // Halted or trapped both pull low

   ////////////////////////////////////////
   // Verdict flags
   ////////////////////////////////////////
   always_ff @(posedge nw) begin
      if (rst) begin
         success <= 1'b0;
         fail    <= 1'b0;
      end else begin
         if (cmd == debug_pkg::CMD_SUCCESS) begin
            success <= 1'b1;               // Sticky until reset
         end
         if (cmd == debug_pkg::CMD_FAIL) begin
            fail <= 1'b1;
         end
      end
   end

endmodule

//--- source/debug_card.sv
////////////////////////////////////////
// Debug I/O card, top level
// Decode stage feeding the register
// block and the run control FSM
////////////////////////////////////////

`timescale 1ns/10ps

module debug_card (
   input  logic                            nw,          // Bus write strobe
   input  logic                            rst,
   input  logic                            niodev1xx,
   input  logic [debug_pkg::AB_W-1:0]      ab,
   input  debug_pkg::word_t                db,
   output debug_pkg::word_t                out_reg,
   output logic [debug_pkg::FPD_W-1:0]     fpd,
   output logic                            print_valid,
   output debug_pkg::print_fmt_t           print_fmt,
   output debug_pkg::long_t                print_data,
   output logic                            unsup_valid,
   output debug_pkg::io_addr_t             unsup_addr,
   output logic                            nhalt,
   output debug_pkg::halt_reason_t         halt_reason,
   output debug_pkg::io_addr_t             bad_addr,
   output logic                            success,
   output logic                            fail
);

   // Decoded command and its payload
   debug_pkg::cmd_t        dec_cmd;
   debug_pkg::print_fmt_t  dec_fmt;
   debug_pkg::word_t       dec_data;
   debug_pkg::io_addr_t    dec_addr;

   debug_decode u_decode (
      .nw        (nw),
      .rst       (rst),
      .niodev1xx (niodev1xx),
      .ab        (ab[debug_pkg::IO_ADDR_W-1:0]),  // Page offset only
      .db        (db),
      .cmd       (dec_cmd),
      .fmt       (dec_fmt),
      .cmd_data  (dec_data),
      .cmd_addr  (dec_addr)
   );

   debug_regs u_regs (
      .nw          (nw),
      .rst         (rst),
      .cmd         (dec_cmd),
      .fmt         (dec_fmt),
      .cmd_data    (dec_data),
      .cmd_addr    (dec_addr),
      .out_reg     (out_reg),
      .fpd         (fpd),
      .print_valid (print_valid),
      .print_fmt   (print_fmt),
      .print_data  (print_data),
      .unsup_valid (unsup_valid),
      .unsup_addr  (unsup_addr)
   );

   run_control u_run (
      .nw          (nw),
      .rst         (rst),
      .cmd         (dec_cmd),
      .cmd_addr    (dec_addr),
      .nhalt       (nhalt),
      .halt_reason (halt_reason),
      .bad_addr    (bad_addr),
      .success     (success),
      .fail        (fail)
   );

endmodule

//--- verification/debug_card_checker.sv
////////////////////////////////////////
// Debug card checker
// Two-stage reference model of the card,
// compared with the DUT every cycle
////////////////////////////////////////

`timescale 1ns/10ps

module debug_card_checker (
   input  logic                        nw,
   input  logic                        rst,
   input  logic                        niodev1xx,
   input  logic [debug_pkg::AB_W-1:0]  ab,
   input  debug_pkg::word_t            db,
   input  debug_pkg::word_t            out_reg,
   input  logic [debug_pkg::FPD_W-1:0] fpd,
   input  logic                        print_valid,
   input  debug_pkg::print_fmt_t       print_fmt,
   input  debug_pkg::long_t            print_data,
   input  logic                        unsup_valid,
   input  debug_pkg::io_addr_t         unsup_addr,
   input  logic                        nhalt,
   input  debug_pkg::halt_reason_t     halt_reason,
   input  debug_pkg::io_addr_t         bad_addr,
   input  logic                        success,
   input  logic                        fail,
   output int                          value_errs,
   output int                          pulse_errs,
   output int                          checks
);

   logic                    ready;        // Set once reset was seen
   logic                    wr_q;         // Write waiting in stage one
   debug_pkg::io_addr_t     addr_q;
   debug_pkg::word_t        data_q;
   debug_pkg::word_t        exp_out;
   debug_pkg::word_t        exp_hi;
   logic                    exp_pv;
   debug_pkg::print_fmt_t   exp_fmt;
   debug_pkg::long_t        exp_pdata;
   logic                    exp_uv;
   debug_pkg::io_addr_t     exp_uaddr;
   debug_pkg::halt_reason_t exp_reason;   // RSN_NONE while running
   debug_pkg::io_addr_t     exp_bad;
   logic                    exp_succ;
   logic                    exp_fail;

   initial begin
      ready      = 1'b0;
      value_errs = 0;
      pulse_errs = 0;
      checks     = 0;
   end

   // Format by offset from PRINTA with SP and NL last
   function automatic debug_pkg::print_fmt_t fmt_of_print(input int offset);
      case (offset)
         0:       fmt_of_print = debug_pkg::FMT_ADDR;
         1:       fmt_of_print = debug_pkg::FMT_CHAR;
         2:       fmt_of_print = debug_pkg::FMT_SDEC;
         3:       fmt_of_print = debug_pkg::FMT_UDEC;
         4:       fmt_of_print = debug_pkg::FMT_HEX;
         5:       fmt_of_print = debug_pkg::FMT_BIN;
         default: fmt_of_print = debug_pkg::FMT_CHAR;
      endcase
   endfunction

   task automatic stop_with(input debug_pkg::halt_reason_t why);
      if (exp_reason == debug_pkg::RSN_NONE) exp_reason = why;   // First stop wins
   endtask

   // Effect of one write one edge after decode
   task automatic apply_write(input debug_pkg::io_addr_t a, input debug_pkg::word_t d);
      if (a == debug_pkg::ADDR_SOR) begin
         exp_out = d;
      end else if (a >= debug_pkg::ADDR_PRINTA && a <= debug_pkg::ADDR_PRINTNL) begin
         exp_pv    = 1'b1;
         exp_fmt   = fmt_of_print(a - debug_pkg::ADDR_PRINTA);
         exp_pdata = {16'h0000, d};
         if (a == debug_pkg::ADDR_PRINTSP) exp_pdata = 32'd32;
         if (a == debug_pkg::ADDR_PRINTNL) exp_pdata = 32'd10;
      end else if (a == debug_pkg::ADDR_PRINTHI) begin
         exp_hi = d;                        // No record
      end else if (a == debug_pkg::ADDR_PRINTLO) begin
         exp_pv    = 1'b1;
         exp_fmt   = debug_pkg::FMT_LONG;
         exp_pdata = {exp_hi, d};
      end else if (a == debug_pkg::ADDR_ENEF || a == debug_pkg::ADDR_DISEF ||
                   a == debug_pkg::ADDR_DEBUGON || a == debug_pkg::ADDR_DEBUGOFF ||
                   a == debug_pkg::ADDR_DUMP) begin
         exp_uv    = 1'b1;
         exp_uaddr = a;
      end else if (a == debug_pkg::ADDR_SUCCESS) begin
         exp_succ = 1'b1;
      end else if (a == debug_pkg::ADDR_FAIL) begin
         exp_fail = 1'b1;
      end else if (a == debug_pkg::ADDR_HALT) begin
         stop_with(debug_pkg::RSN_HALT);
      end else if (a == debug_pkg::ADDR_SENTINEL) begin
         stop_with(debug_pkg::RSN_SENTINEL);
      end else begin
         if (exp_reason == debug_pkg::RSN_NONE) exp_bad = a;   // Only while running
         stop_with(debug_pkg::RSN_UNKNOWN);
      end
   endtask

   ////////////////////////////////////////
   // Model advanced on each write edge
   ////////////////////////////////////////
   always @(posedge nw) begin
      if (rst) begin
         ready      = 1'b1;
         wr_q       = 1'b0;
         exp_out    = '0;
         exp_hi     = '0;
         exp_pv     = 1'b0;
         exp_uv     = 1'b0;
         exp_reason = debug_pkg::RSN_NONE;
         exp_bad    = '0;
         exp_succ   = 1'b0;
         exp_fail   = 1'b0;
      end else if (ready) begin
         exp_pv = 1'b0;
         exp_uv = 1'b0;
         if (wr_q) apply_write(addr_q, data_q);
         wr_q   = !niodev1xx;               // Card selected on this edge
         addr_q = ab[7:0];
         data_q = db;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         value_errs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // Outputs are settled by the falling edge
   always @(negedge nw) begin
      if (ready) begin
         checks++;
         if (print_valid !== exp_pv) begin
            pulse_errs++;
            if (exp_pv) $display("Missing print pulse at %0t", $time);
            else $display("Extra print pulse at %0t", $time);
         end else if (exp_pv) begin
            check_value("print_fmt", print_fmt, exp_fmt);
            check_value("print_data", print_data, exp_pdata);
         end
         if (unsup_valid !== exp_uv) begin
            pulse_errs++;
            if (exp_uv) $display("Missing unsupported pulse at %0t", $time);
            else $display("Extra unsupported pulse at %0t", $time);
         end else if (exp_uv) begin
            check_value("unsup_addr", unsup_addr, exp_uaddr);
         end
         check_value("out_reg", out_reg, exp_out);
         check_value("fpd", fpd, exp_out[7:0]);
         check_value("nhalt", nhalt, exp_reason == debug_pkg::RSN_NONE);
         check_value("halt_reason", halt_reason, exp_reason);
         check_value("bad_addr", bad_addr, exp_bad);
         check_value("success", success, exp_succ);
         check_value("fail", fail, exp_fail);
      end
   end

endmodule

//--- verification/tb_debug_card.sv
////////////////////////////////////////
// Debug card testbench
// Clock, reset, directed writes from the
// stimulus file, random writes, timeout
////////////////////////////////////////

`timescale 1ns/10ps

module tb_debug_card;

   localparam int    RANDOM_WRITES = 200;
   localparam int    DRIVE_DELAY   = 2;     // ns after the rising edge
   localparam int    HALF_PERIOD   = 20;    // 40 ns strobe period
   localparam string STIM_FILE     = "verification/debug_card_stimulus.txt";

   logic                                  nw;
   logic                                  rst;
   logic                                  niodev1xx;
   logic [debug_pkg::AB_W-1:0]            ab;
   debug_pkg::word_t                      db;
   debug_pkg::word_t                      out_reg;
   logic [debug_pkg::FPD_W-1:0]           fpd;
   logic                                  print_valid;
   debug_pkg::print_fmt_t                 print_fmt;
   debug_pkg::long_t                      print_data;
   logic                                  unsup_valid;
   debug_pkg::io_addr_t                   unsup_addr;
   logic                                  nhalt;
   debug_pkg::halt_reason_t               halt_reason;
   debug_pkg::io_addr_t                   bad_addr;
   logic                                  success;
   logic                                  fail;

   int                        value_errs;
   int                        pulse_errs;
   int                        checks;
   int                        other_errs;
   int                        cycle_count;
   int                        cycle_limit;
   int unsigned               lcg_state;
   int                        gap_q[$];
   logic [debug_pkg::AB_W-1:0] addr_q[$];
   debug_pkg::word_t          data_q[$];

   debug_card i_dut (
      .nw (nw), .rst (rst), .niodev1xx (niodev1xx), .ab (ab), .db (db),
      .out_reg (out_reg), .fpd (fpd),
      .print_valid (print_valid), .print_fmt (print_fmt), .print_data (print_data),
      .unsup_valid (unsup_valid), .unsup_addr (unsup_addr),
      .nhalt (nhalt), .halt_reason (halt_reason), .bad_addr (bad_addr),
      .success (success), .fail (fail)
   );

   debug_card_checker u_checker (
      .nw (nw), .rst (rst), .niodev1xx (niodev1xx), .ab (ab), .db (db),
      .out_reg (out_reg), .fpd (fpd),
      .print_valid (print_valid), .print_fmt (print_fmt), .print_data (print_data),
      .unsup_valid (unsup_valid), .unsup_addr (unsup_addr),
      .nhalt (nhalt), .halt_reason (halt_reason), .bad_addr (bad_addr),
      .success (success), .fail (fail),
      .value_errs (value_errs), .pulse_errs (pulse_errs), .checks (checks)
   );

   initial begin
      nw = 1'b0;
      forever #HALF_PERIOD nw = ~nw;
   end

   // Run limit scaled from the test length
   always @(posedge nw) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic int unsigned next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state >> 8;                // Low bits are weak
   endfunction

   // Random pool of SOR, print, PRINTHI/LO and unsupported addresses
   function automatic debug_pkg::io_addr_t pick_addr(input int unsigned idx);
      case (idx)
         0:       pick_addr = debug_pkg::ADDR_SOR;
         1, 2, 3, 4, 5, 6, 7, 8:
                  pick_addr = debug_pkg::ADDR_PRINTA + debug_pkg::io_addr_t'(idx - 1);
         9:       pick_addr = debug_pkg::ADDR_PRINTHI;
         10:      pick_addr = debug_pkg::ADDR_PRINTLO;
         11:      pick_addr = debug_pkg::ADDR_ENEF;
         12:      pick_addr = debug_pkg::ADDR_DISEF;
         13:      pick_addr = debug_pkg::ADDR_DEBUGON;
         14:      pick_addr = debug_pkg::ADDR_DEBUGOFF;
         default: pick_addr = debug_pkg::ADDR_DUMP;
      endcase
   endfunction

   task automatic hold_reset();
      rst       = 1'b1;
      niodev1xx = 1'b1;
      repeat (4) @(posedge nw);
      #DRIVE_DELAY;
      rst = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge nw);
         #DRIVE_DELAY;
         niodev1xx = 1'b1;                  // No card access
      end
   endtask

   // The card is selected only for addresses 100-1FF
   task automatic bus_write(input logic [debug_pkg::AB_W-1:0] a, input debug_pkg::word_t d);
      @(posedge nw);
      #DRIVE_DELAY;
      ab        = a;
      db        = d;
      niodev1xx = (a[debug_pkg::AB_W-1:8] != 16'h0001);
   endtask

   task automatic load_stimulus(output int gap_sum);
      int                         fd;
      int                         code;
      int                         g;
      logic [debug_pkg::AB_W-1:0] a;
      debug_pkg::word_t           d;
      logic [8*160-1:0]           skip_buf;
      gap_sum = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open stimulus file %s", STIM_FILE);
         other_errs++;
         return;
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%d %h %h\n", g, a, d);
         if (code == 3) begin
            gap_q.push_back(g);
            addr_q.push_back(a);
            data_q.push_back(d);
            gap_sum += g;
         end else begin
            code = $fgets(skip_buf, fd);    // Comment or blank line
         end
      end
      $fclose(fd);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      int               gap_sum;
      int unsigned      r;
      debug_pkg::word_t d;
      logic [23:0]      page;
      rst         = 1'b1;
      niodev1xx   = 1'b1;
      ab          = '0;
      db          = '0;
      other_errs  = 0;
      cycle_count = 0;
      cycle_limit = (RANDOM_WRITES + 20) * 2;
      lcg_state   = 98900;
      load_stimulus(gap_sum);
      if (gap_q.size() == 0) begin
         $display("Stimulus file holds no writes");
         other_errs++;
      end
      cycle_limit = (gap_sum + gap_q.size() + RANDOM_WRITES + 20) * 2;
      hold_reset();
      idle(2);                              // Quiet cycles after reset
      foreach (gap_q[i]) begin
         idle(gap_q[i]);
         bus_write(addr_q[i], data_q[i]);
      end
      for (int i = 0; i < RANDOM_WRITES; i++) begin
         r = next_random();
         if (r % 4 == 0) idle(1);
         page = (next_random() % 8 == 0) ? 24'h000200 : 24'h000100;  // Some off-page
         d    = debug_pkg::word_t'(next_random());
         bus_write({page[23:8], pick_addr(next_random() % 16)}, d);
      end
      // Verdicts, halt, then stops that must not count
      bus_write(24'h00011E, 16'h0001);
      bus_write(24'h00011F, 16'h0001);
      bus_write(24'h00011D, 16'h0000);
      bus_write(24'h00011D, 16'h0000);
      bus_write(24'h00010F, 16'h0000);
      bus_write(24'h0001C0, 16'h0000);
      bus_write(24'h000114, 16'hABCD);     // Prints still flow when halted
      bus_write(24'h000117, 16'h5A5A);
      idle(4);
      hold_reset();                         // Fresh run with an unknown address first
      idle(1);
      bus_write(24'h000105, 16'h7777);
      idle(4);
      if (checks == 0) begin
         $display("Checker compared no outputs");
         other_errs++;
      end
      $display("Errors: %0d value, %0d pulse, %0d other, over %0d checked cycles",
               value_errs, pulse_errs, other_errs, checks);
      if (value_errs + pulse_errs + other_errs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- verification/debug_card_stimulus.txt
# Columns: idle gap (decimal cycles), bus address (hex), data word (hex)
# Addresses outside 100-1FF are written with niodev1xx high
# Output register, then off-page writes that must change nothing
0 100 1234
2 100 a55a
0 200 ffff
0 000 beef
1 01c 5555
# Every print format, back to back
1 110 0123
0 111 0041
0 112 8001
0 113 8001
0 114 cafe
0 115 00f0
0 116 ffff
0 117 1234
# 32-bit prints, and a lone PRINTHI
1 11b dead
0 11c beef
0 11c 0001
0 11b 1111
2 11c 2222
0 11b 3333
# Known but unsupported commands
1 108 0000
0 109 0001
0 118 0002
0 119 0003
0 11a 0004
3 100 00ff

//--- debug_card.f
source/debug_pkg.sv
source/debug_decode.sv
source/debug_regs.sv
source/run_control.sv
source/debug_card.sv
verification/debug_card_checker.sv
verification/tb_debug_card.sv
